// ==== lumi_tx_settings.svh ====
// Link transmitter settings: UMI field widths, phy width and counter widths
`ifndef LUMI_TX_SETTINGS_SVH
`define LUMI_TX_SETTINGS_SVH

// ##############################
// UMI field widths
// ##############################
`define LUMI_DW    64    // Data field, capped payload per packet
`define LUMI_AW    32    // Destination and source address
`define LUMI_CW    32    // Command word

// ##############################
// Link side
// ##############################
`define LUMI_IOW   64    // Phy bus, up to 8 bytes per line
`define LUMI_CRDTW 16    // Credit counters wrap modulo 2^16
`define LUMI_CNTW  8     // Byte and line counts

// Full packet as held in the shift register
`define LUMI_PKTW  (`LUMI_DW + 2 * `LUMI_AW + `LUMI_CW)
`define LUMI_PKTB  (`LUMI_PKTW / 8)

`endif

// ==== lumi_tx_pkg.sv ====
// Link transmitter types: opcode encoding, packet class and packet vector
`include "lumi_tx_settings.svh"

package lumi_tx_pkg;

   // ##############################
   // Command word layout
   // ##############################
   // Opcode  cmd[4:0]
   // Size    cmd[7:5]   log2 of bytes per word
   // Length  cmd[15:8]  words minus one
   // Upper bits travel untouched

   // Opcodes the transmitter tells apart, others count as carrying data
   typedef enum logic [4:0] {
      UMI_INVALID    = 5'h00,  // Empty command
      UMI_REQ_READ   = 5'h01,
      UMI_RESP_READ  = 5'h02,  // Returns read data
      UMI_REQ_WRITE  = 5'h03,
      UMI_RESP_WRITE = 5'h04,  // Write ack, header only
      UMI_REQ_POSTED = 5'h05,  // Write without ack
      UMI_REQ_RDMA   = 5'h07,
      UMI_REQ_ATOMIC = 5'h09,
      UMI_LINK       = 5'h0E   // Link layer message, command only
   } umi_opcode_t;

   // How much of the packet goes on the wire
   typedef enum logic [1:0] {
      PKT_CMD_ONLY  = 2'd0,    // Command word only
      PKT_NO_DATA   = 2'd1,    // Command and both addresses
      PKT_WITH_DATA = 2'd2     // Header plus data bytes
   } pkt_class_t;

   // Packet as serialized, lsb first
   // {data, srcaddr, dstaddr, cmd}
   typedef logic [`LUMI_PKTW-1:0] pkt_vec_t;

endpackage

// ==== lumi_tx_decode.sv ====
// Command decode for one channel: packet class, byte count and credit lines needed
`include "lumi_tx_settings.svh"

module lumi_tx_decode
  (
   input  logic [`LUMI_CW-1:0]     cmd,          // UMI command word
   input  logic [1:0]              csr_iowidth,  // log2 bytes per phy line
   output lumi_tx_pkg::pkt_class_t pkt_class,    // How much goes on the wire
   output logic [`LUMI_CNTW-1:0]   pkt_bytes,    // Bytes on the wire
   output logic [`LUMI_CNTW-1:0]   crdt_need     // Phy lines, rounded up
   );

   import lumi_tx_pkg::*;

   localparam logic [`LUMI_CNTW-1:0] CMD_BYTES = `LUMI_CW / 8;
   localparam logic [`LUMI_CNTW-1:0] HDR_BYTES = (`LUMI_CW + 2 * `LUMI_AW) / 8;
   localparam logic [`LUMI_CNTW-1:0] DATA_MAX  = `LUMI_DW / 8;  // Data field size

   umi_opcode_t            opcode;
   logic [2:0]             size;
   logic [7:0]             len;
   logic [8:0]             lenp1;      // Words in the transfer
   logic [15:0]            data_raw;   // Bytes the command asks for
   logic [`LUMI_CNTW-1:0]  data_bytes; // Bytes actually sent
   logic [`LUMI_CNTW-1:0]  lines;      // Whole lines
   logic [`LUMI_CNTW-1:0]  rem;        // Bytes spilling into a partial line

   // ##############################
   // Field extraction
   // ##############################
   assign opcode = umi_opcode_t'(cmd[4:0]);
   assign size   = cmd[7:5];
   assign len    = cmd[15:8];

   // (len+1) << size, at most 256 << 7
   assign lenp1    = {1'b0, len} + 9'd1;
   assign data_raw = {7'd0, lenp1} << size;

   // Longer transfers are cut to the data field
   assign data_bytes = (data_raw > 16'(DATA_MAX)) ? DATA_MAX : data_raw[`LUMI_CNTW-1:0];

   // ##############################
   // Packet class
   // ##############################
   always_comb
   begin
      case (opcode)
         UMI_INVALID,
         UMI_LINK       : pkt_class = PKT_CMD_ONLY;
         UMI_REQ_READ,
         UMI_REQ_RDMA,
         UMI_RESP_WRITE : pkt_class = PKT_NO_DATA;   // Addresses, no payload
         default        : pkt_class = PKT_WITH_DATA;
      endcase
   end

   always_comb
   begin
      case (pkt_class)
         PKT_CMD_ONLY : pkt_bytes = CMD_BYTES;
         PKT_NO_DATA  : pkt_bytes = HDR_BYTES;
         default      : pkt_bytes = HDR_BYTES + data_bytes;
      endcase
   end

   // ##############################
   // Credit lines
   // ##############################
   // Round down by shift, then look for leftover bytes under the line mask
   assign lines = pkt_bytes >> csr_iowidth;
   assign rem   = pkt_bytes & ~(lines << csr_iowidth);

   assign crdt_need = lines + {{(`LUMI_CNTW-1){1'b0}}, |rem};  // One more for a partial line

endmodule

// ==== lumi_tx_arbiter.sv ====
// Credit check and response-over-request arbitration with transmitted-line counters
`include "lumi_tx_settings.svh"

module lumi_tx_arbiter
  (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    csr_en,         // Transmitter enable
   // Channel requests
   input  logic                    req_valid,
   input  logic                    resp_valid,
   input  logic [`LUMI_CNTW-1:0]   req_need,       // Lines for the pending request
   input  logic [`LUMI_CNTW-1:0]   resp_need,      // Lines for the pending response
   // Remote grants, cumulative
   input  logic [`LUMI_CRDTW-1:0]  rmt_crdt_req,
   input  logic [`LUMI_CRDTW-1:0]  rmt_crdt_resp,
   // Serializer side
   input  logic                    load_ready,     // Serializer can take a packet
   output logic                    req_ready,
   output logic                    resp_ready,
   output logic                    load,           // Packet accepted this edge
   output logic                    sel_resp        // Accepted packet is the response
   );

   import lumi_tx_pkg::*;

   logic [`LUMI_CRDTW-1:0] tx_crdt_req;     // Lines sent on the request channel
   logic [`LUMI_CRDTW-1:0] tx_crdt_resp;    // Lines sent on the response channel
   logic [`LUMI_CRDTW-1:0] req_avail;
   logic [`LUMI_CRDTW-1:0] resp_avail;
   logic [`LUMI_CRDTW-1:0] req_need_ext;
   logic [`LUMI_CRDTW-1:0] resp_need_ext;
   logic                   req_elig;
   logic                   resp_elig;
   logic                   req_acc;
   logic                   resp_acc;

   // ##############################
   // Available credit
   // ##############################
   // Difference wraps with the counters
   assign req_avail  = rmt_crdt_req  - tx_crdt_req;
   assign resp_avail = rmt_crdt_resp - tx_crdt_resp;

   assign req_need_ext  = {{(`LUMI_CRDTW-`LUMI_CNTW){1'b0}}, req_need};
   assign resp_need_ext = {{(`LUMI_CRDTW-`LUMI_CNTW){1'b0}}, resp_need};

   // Strictly greater, one line always kept in reserve
   assign req_elig  = csr_en & load_ready & (req_avail  > req_need_ext);
   assign resp_elig = csr_en & load_ready & (resp_avail > resp_need_ext);

   // ##############################
   // Priority
   // ##############################
   // Response wins whenever it could go
   assign resp_ready = resp_elig;
   assign req_ready  = req_elig & ~(resp_valid & resp_elig);

   assign resp_acc = resp_valid & resp_ready;
   assign req_acc  = req_valid  & req_ready;     // Never together with resp_acc

   assign load     = resp_acc | req_acc;
   assign sel_resp = resp_acc;

   // ##############################
   // Transmitted-line counters
   // ##############################
   // Whole packet charged at acceptance
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_crdt_req  <= '0;
         tx_crdt_resp <= '0;
      end
      else
      begin
         if (req_acc)
            tx_crdt_req <= tx_crdt_req + req_need_ext;
         if (resp_acc)
            tx_crdt_resp <= tx_crdt_resp + resp_need_ext;
      end
   end

endmodule

// ==== lumi_tx_serializer.sv ====
// Packet serializer: shift register with byte-valid mask driving the phy lines
`include "lumi_tx_settings.svh"

module lumi_tx_serializer
  (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   load,          // Take a new packet
   input  lumi_tx_pkg::pkt_vec_t  pkt,           // Packet, lsb first
   input  logic [`LUMI_CNTW-1:0]  pkt_bytes,     // Bytes of pkt on the wire
   input  logic [1:0]             csr_iowidth,   // log2 bytes per line
   input  logic                   phy_txrdy,     // Phy consumes the line
   output logic                   load_ready,    // Free now or after this edge
   output logic [`LUMI_IOW-1:0]   phy_txdata,
   output logic                   phy_txvld
   );

   import lumi_tx_pkg::*;

   pkt_vec_t               shiftreg;        // Packet bytes still to send
   logic [`LUMI_PKTB-1:0]  vmask;           // One bit per remaining byte
   logic [`LUMI_PKTB-1:0]  vmask_next;      // After the current line
   logic [`LUMI_PKTB-1:0]  load_mask;
   logic [3:0]             bpc;             // Bytes per line
   logic [6:0]             bpc_bits;        // Same in bits
   logic [`LUMI_IOW-1:0]   width_mask;      // Lanes in use
   logic [`LUMI_IOW-1:0]   byte_mask;       // Lanes holding packet bytes
   logic                   line_done;
   logic                   last_line;

   // ##############################
   // Line width
   // ##############################
   assign bpc        = 4'd1 << csr_iowidth;
   assign bpc_bits   = {bpc, 3'b000};
   assign width_mask = ~({`LUMI_IOW{1'b1}} << bpc_bits);  // All ones at 8 bytes

   // ##############################
   // Byte-valid mask
   // ##############################
   assign load_mask  = ~({`LUMI_PKTB{1'b1}} << pkt_bytes);
   assign vmask_next = vmask >> bpc;

   assign phy_txvld  = |vmask;
   assign line_done  = phy_txvld & phy_txrdy;
   assign last_line  = ~|vmask_next;             // Nothing left past this line
   assign load_ready = ~phy_txvld | (last_line & phy_txrdy);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         vmask <= '0;
      else if (load)
         vmask <= load_mask;                      // Last line drains on the same edge
      else if (line_done)
         vmask <= vmask_next;
   end

   // ##############################
   // Data path
   // ##############################
   always_ff @(posedge clk)
   begin
      if (load)
         shiftreg <= pkt;
      else if (line_done)
         shiftreg <= shiftreg >> bpc_bits;
   end

   // Expand the low mask bits to lanes
   always_comb
   begin
      for (int i = 0; i < `LUMI_IOW / 8; i++)
      begin
         byte_mask[i*8 +: 8] = {8{vmask[i]}};
      end
   end

   // Zero past the packet end and above the line width
   assign phy_txdata = shiftreg[`LUMI_IOW-1:0] & width_mask & byte_mask;

endmodule

// ==== lumi_tx.sv ====
// Link transmitter top: decodes, arbitrates and serializes two UMI channels
`include "lumi_tx_settings.svh"

module lumi_tx
  (
   input  logic                   clk,
   input  logic                   nreset,
   // Configuration
   input  logic                   csr_en,              // Enable transmission
   input  logic [1:0]             csr_iowidth,         // 1, 2, 4 or 8 bytes per line
   input  logic [`LUMI_CRDTW-1:0] rmt_crdt_req,        // Remote grants, request
   input  logic [`LUMI_CRDTW-1:0] rmt_crdt_resp,       // Remote grants, response
   // Request channel
   input  logic                   umi_req_in_valid,
   input  logic [`LUMI_CW-1:0]    umi_req_in_cmd,
   input  logic [`LUMI_AW-1:0]    umi_req_in_dstaddr,
   input  logic [`LUMI_AW-1:0]    umi_req_in_srcaddr,
   input  logic [`LUMI_DW-1:0]    umi_req_in_data,
   output logic                   umi_req_in_ready,
   // Response channel, higher priority
   input  logic                   umi_resp_in_valid,
   input  logic [`LUMI_CW-1:0]    umi_resp_in_cmd,
   input  logic [`LUMI_AW-1:0]    umi_resp_in_dstaddr,
   input  logic [`LUMI_AW-1:0]    umi_resp_in_srcaddr,
   input  logic [`LUMI_DW-1:0]    umi_resp_in_data,
   output logic                   umi_resp_in_ready,
   // Phy
   output logic [`LUMI_IOW-1:0]   phy_txdata,
   output logic                   phy_txvld,
   input  logic                   phy_txrdy            // Back-pressure
   );

   import lumi_tx_pkg::*;

   pkt_class_t             req_class;
   pkt_class_t             resp_class;
   logic [`LUMI_CNTW-1:0]  req_bytes;
   logic [`LUMI_CNTW-1:0]  resp_bytes;
   logic [`LUMI_CNTW-1:0]  req_need;
   logic [`LUMI_CNTW-1:0]  resp_need;
   logic [`LUMI_CNTW-1:0]  sel_bytes;
   logic [`LUMI_DW-1:0]    req_data;      // Cleared when not sent
   logic [`LUMI_DW-1:0]    resp_data;
   logic                   load_ready;
   logic                   load;
   logic                   sel_resp;
   pkt_vec_t               pkt;

   // ##############################
   // Decode, one per channel
   // ##############################
   lumi_tx_decode u_decode_req
     (.cmd         (umi_req_in_cmd),
      .csr_iowidth (csr_iowidth),
      .pkt_class   (req_class),
      .pkt_bytes   (req_bytes),
      .crdt_need   (req_need));

   lumi_tx_decode u_decode_resp
     (.cmd         (umi_resp_in_cmd),
      .csr_iowidth (csr_iowidth),
      .pkt_class   (resp_class),
      .pkt_bytes   (resp_bytes),
      .crdt_need   (resp_need));

   // ##############################
   // Credit check and priority
   // ##############################
   lumi_tx_arbiter u_arbiter
     (.clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .req_valid     (umi_req_in_valid),
      .resp_valid    (umi_resp_in_valid),
      .req_need      (req_need),
      .resp_need     (resp_need),
      .rmt_crdt_req  (rmt_crdt_req),
      .rmt_crdt_resp (rmt_crdt_resp),
      .load_ready    (load_ready),
      .req_ready     (umi_req_in_ready),
      .resp_ready    (umi_resp_in_ready),
      .load          (load),
      .sel_resp      (sel_resp));

   // ##############################
   // Packet assembly
   // ##############################
   // Data field only loaded when the packet carries it
   assign req_data  = (req_class  == PKT_WITH_DATA) ? umi_req_in_data  : '0;
   assign resp_data = (resp_class == PKT_WITH_DATA) ? umi_resp_in_data : '0;

   assign pkt = sel_resp ?
                {resp_data, umi_resp_in_srcaddr, umi_resp_in_dstaddr, umi_resp_in_cmd} :
                {req_data,  umi_req_in_srcaddr,  umi_req_in_dstaddr,  umi_req_in_cmd};

   assign sel_bytes = sel_resp ? resp_bytes : req_bytes;

   lumi_tx_serializer u_serializer
     (.clk         (clk),
      .nreset      (nreset),
      .load        (load),
      .pkt         (pkt),
      .pkt_bytes   (sel_bytes),
      .csr_iowidth (csr_iowidth),
      .phy_txrdy   (phy_txrdy),
      .load_ready  (load_ready),
      .phy_txdata  (phy_txdata),
      .phy_txvld   (phy_txvld));

endmodule

// ==== tb_lumi_tx.sv ====
// Link transmitter testbench: reference lines, stimulus per channel, phy line compare
`include "lumi_tx_settings.svh"

module tb_lumi_tx;

   localparam int TMO = 500;          // Cycles any wait may take

   logic                   clk;
   logic                   nreset;
   logic                   csr_en;
   logic [1:0]             csr_iowidth;
   logic [`LUMI_CRDTW-1:0] rmt_crdt_req;
   logic [`LUMI_CRDTW-1:0] rmt_crdt_resp;
   logic                   req_valid, resp_valid;
   logic [`LUMI_CW-1:0]    req_cmd, resp_cmd;
   logic [`LUMI_AW-1:0]    req_dst, req_src, resp_dst, resp_src;
   logic [`LUMI_DW-1:0]    req_data, resp_data;
   logic                   req_ready, resp_ready;
   logic [`LUMI_IOW-1:0]   phy_txdata;
   logic                   phy_txvld;
   logic                   phy_txrdy;

   integer                 seed = 32'h2b6e_bee0;
   bit                     rdy_random;          // Random phy back-pressure on
   bit                     crdt_step;           // Remote grants a line per waiting cycle
   logic [63:0]            exp_lines[$];        // Expected phy lines in order
   int                     sent_req, sent_resp; // Lines charged by acceptance
   int                     errors, tests;

   lumi_tx u_lumi_tx
     (.clk(clk), .nreset(nreset), .csr_en(csr_en), .csr_iowidth(csr_iowidth),
      .rmt_crdt_req(rmt_crdt_req), .rmt_crdt_resp(rmt_crdt_resp),
      .umi_req_in_valid(req_valid), .umi_req_in_cmd(req_cmd),
      .umi_req_in_dstaddr(req_dst), .umi_req_in_srcaddr(req_src),
      .umi_req_in_data(req_data), .umi_req_in_ready(req_ready),
      .umi_resp_in_valid(resp_valid), .umi_resp_in_cmd(resp_cmd),
      .umi_resp_in_dstaddr(resp_dst), .umi_resp_in_srcaddr(resp_src),
      .umi_resp_in_data(resp_data), .umi_resp_in_ready(resp_ready),
      .phy_txdata(phy_txdata), .phy_txvld(phy_txvld), .phy_txrdy(phy_txrdy));

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ##############################
   // Reference model
   // ##############################
   function automatic int ref_bytes(input logic [31:0] cmd);
      int data_b;
      case (cmd[4:0])
         5'h00, 5'h0E        : return 4;            // Command only
         5'h01, 5'h07, 5'h04 : return 12;           // Header, no data
         default             :
         begin
            data_b = (int'(cmd[15:8]) + 1) << cmd[7:5];
            if (data_b > 8)
               data_b = 8;
            return 12 + data_b;
         end
      endcase
   endfunction

   // Line k of the packet at bpc bytes per line
   function automatic logic [63:0] ref_line(input logic [159:0] pkt, input int nbytes,
                                            input int bpc, input int k);
      logic [63:0] line;
      line = '0;
      for (int j = 0; j < bpc; j++)
         if (k * bpc + j < nbytes)
            line[j*8 +: 8] = pkt[(k*bpc+j)*8 +: 8];
      return line;
   endfunction

   task automatic push_expected(input bit resp, input logic [31:0] cmd,
                                input logic [31:0] dst, input logic [31:0] src,
                                input logic [63:0] data);
      int nb, bpc, nl;
      int granted, charged;
      nb  = ref_bytes(cmd);
      bpc = 1 << csr_iowidth;
      nl  = (nb + bpc - 1) / bpc;
      granted = resp ? rmt_crdt_resp : rmt_crdt_req;
      charged = resp ? sent_resp : sent_req;
      // Credit left must exceed the lines of this packet
      if (granted - charged <= nl)
      begin
         $display("Error at %0t: packet accepted without enough credit", $time);
         errors++;
      end
      for (int k = 0; k < nl; k++)
         exp_lines.push_back(ref_line({data, src, dst, cmd}, nb, bpc, k));
      if (resp)
         sent_resp += nl;
      else
         sent_req += nl;
   endtask

   function automatic int ref_need(input logic [31:0] cmd);
      int bpc;
      bpc = 1 << csr_iowidth;
      return (ref_bytes(cmd) + bpc - 1) / bpc;
   endfunction

   // ##############################
   // Checks and waits
   // ##############################
   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic give_up(input string what);
      $display("Timeout: %s", what);
      $display("RESULT: FAIL");
      $finish;
   endtask

   // Phy lines consumed, compared against the queue
   always @(posedge clk)
   begin
      if (nreset && phy_txvld && phy_txrdy)
      begin
         if (exp_lines.size() == 0)
         begin
            $display("Error at %0t: phy line %h sent with none expected", $time, phy_txdata);
            errors++;
         end
         else
            check_value("phy line", phy_txdata, exp_lines.pop_front());
      end
   end

   initial
   begin
      logic rdy_next;
      phy_txrdy = 1'b1;
      forever
      begin
         @(posedge clk);
         rdy_next = $random(seed);                 // Drawn at the rising edge
         @(negedge clk);
         phy_txrdy = rdy_random ? rdy_next : 1'b1;
      end
   end

   task automatic drive(input bit resp, input bit vld, input logic [31:0] cmd,
                        input logic [31:0] dst, input logic [31:0] src,
                        input logic [63:0] data);
      if (resp)
      begin
         resp_valid = vld;
         resp_cmd   = cmd;
         resp_dst   = dst;
         resp_src   = src;
         resp_data  = data;
      end
      else
      begin
         req_valid = vld;
         req_cmd   = cmd;
         req_dst   = dst;
         req_src   = src;
         req_data  = data;
      end
   endtask

   // Called at a falling edge with the channel driven, returns at a falling edge
   task automatic wait_accept(input bit resp);
      bit acc;
      acc = 0;
      for (int t = 0; t < TMO && !acc; t++)
      begin
         #1;
         if (resp ? resp_ready : req_ready)
         begin
            acc = 1;
            if (resp)
               push_expected(1, resp_cmd, resp_dst, resp_src, resp_data);
            else
               push_expected(0, req_cmd, req_dst, req_src, req_data);
         end
         @(negedge clk);
         if (crdt_step && !acc)
         begin
            if (resp)
               rmt_crdt_resp = rmt_crdt_resp + 1'b1;
            else
               rmt_crdt_req = rmt_crdt_req + 1'b1;
         end
      end
      if (!acc)
         give_up(resp ? "response channel never became ready" :
                        "request channel never became ready");
      if (resp)
         resp_valid = 1'b0;
      else
         req_valid = 1'b0;
   endtask

   task automatic send_pkt(input bit resp, input logic [31:0] cmd);
      drive(resp, 1, cmd, $random(seed), $random(seed), {$random(seed), $random(seed)});
      wait_accept(resp);
   endtask

   task automatic wait_idle();
      int t;
      for (t = 0; t < TMO && (exp_lines.size() != 0 || phy_txvld); t++)
         @(negedge clk);
      if (t == TMO)
         give_up("phy lines still pending");
   endtask

   task automatic end_test(input string name, input int err0);
      tests++;
      $display("Test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "failed");
   endtask

   // ##############################
   // Stimulus
   // ##############################
   initial
   begin
      logic [4:0]  ops[9];
      int          err0, need;
      logic [31:0] cmd;
      ops = '{5'h00, 5'h01, 5'h02, 5'h03, 5'h04, 5'h05, 5'h07, 5'h09, 5'h0E};
      nreset        = 0;
      csr_en        = 1;
      csr_iowidth   = 2'd3;
      rdy_random    = 0;
      rmt_crdt_req  = 16'h0400;
      rmt_crdt_resp = 16'h0400;
      drive(0, 0, '0, '0, '0, '0);
      drive(1, 0, '0, '0, '0, '0);
      repeat (5) @(negedge clk);
      nreset = 1;
      @(negedge clk);

      err0 = errors;                                   // Write at each width
      for (int w = 0; w < 4; w++)
      begin
         csr_iowidth = w[1:0];
         send_pkt(0, {16'h0, 8'd0, 3'd3, 5'h03});
         wait_idle();
      end
      end_test("write at each width", err0);

      err0 = errors;                                   // Packet classes and cap
      csr_iowidth = 2'd1;
      foreach (ops[i])
         send_pkt(i % 2, {16'h0, 8'd1, 3'd1, ops[i]});
      send_pkt(0, {16'h0, 8'd5, 3'd2, 5'h03});
      wait_idle();
      end_test("packet classes", err0);

      err0 = errors;                                   // Response priority
      csr_iowidth = 2'd2;
      drive(0, 1, {16'h0, 8'd0, 3'd3, 5'h05}, 32'h1111_0000, 32'h2222_0000, 64'h0123_4567);
      drive(1, 1, {16'h0, 8'd0, 3'd2, 5'h02}, 32'h3333_0000, 32'h4444_0000, 64'h89ab_cdef);
      #1;
      check_value("resp_ready with both valid", resp_ready, 1);
      check_value("req_ready with response pending", req_ready, 0);
      wait_accept(1);
      wait_accept(0);
      wait_idle();
      end_test("response priority", err0);

      err0 = errors;                                   // Credit boundary
      cmd  = {16'h0, 8'd0, 3'd3, 5'h03};
      need = ref_need(cmd);
      rmt_crdt_req = sent_req + need;
      drive(0, 1, cmd, 32'hdead_0001, 32'hbeef_0002, 64'h5555_aaaa_1234_5678);
      for (int c = 0; c < 5; c++)
      begin
         #1;
         check_value("req_ready at exact credit", req_ready, 0);
         @(negedge clk);
      end
      rmt_crdt_req = rmt_crdt_req + 1;
      wait_accept(0);
      crdt_step = 1;
      for (int p = 0; p < 20; p++)                     // Credit granted in steps
      begin
         cmd = {16'h0, 6'd0, 2'($random(seed)), 3'($random(seed)),
                ops[$unsigned($random(seed)) % 9]};
         rmt_crdt_req = rmt_crdt_req + 16'($unsigned($random(seed)) % 4);
         send_pkt(0, cmd);
      end
      crdt_step = 0;
      wait_idle();
      end_test("credit limit", err0);

      err0 = errors;                                   // Random back-pressure stream
      rmt_crdt_req  = sent_req + 2000;
      rmt_crdt_resp = sent_resp + 2000;
      rdy_random = 1;
      for (int p = 0; p < 40; p++)
      begin
         if (p % 10 == 0)
         begin
            wait_idle();
            csr_iowidth = 2'($random(seed));
         end
         cmd = {16'h0, 6'd0, 2'($random(seed)), 3'($random(seed)),
                ops[$unsigned($random(seed)) % 9]};
         send_pkt($random(seed), cmd);
      end
      wait_idle();
      rdy_random = 0;
      end_test("random stream", err0);

      err0 = errors;                                   // Disabled transmitter
      csr_en = 0;
      drive(0, 1, {16'h0, 8'd0, 3'd3, 5'h03}, '0, '0, '0);
      drive(1, 1, {16'h0, 8'd0, 3'd3, 5'h02}, '0, '0, '0);
      for (int c = 0; c < 10; c++)
      begin
         #1;
         check_value("req_ready while disabled", req_ready, 0);
         check_value("resp_ready while disabled", resp_ready, 0);
         check_value("phy_txvld while disabled", phy_txvld, 0);
         @(negedge clk);
      end
      req_valid  = 0;
      resp_valid = 0;
      @(negedge clk);
      csr_en = 1;
      end_test("disabled", err0);

      $display("Tests run %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+.
lumi_tx_pkg.sv
lumi_tx_decode.sv
lumi_tx_arbiter.sv
lumi_tx_serializer.sv
lumi_tx.sv
tb_lumi_tx.sv

// ==== Bender.yml ====
package:
  name: lumi_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lumi_tx_pkg.sv
      - lumi_tx_decode.sv
      - lumi_tx_arbiter.sv
      - lumi_tx_serializer.sv
      - lumi_tx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lumi_tx.sv
